/* fetch_top.f */
verilog/fetch_pkg.sv
verilog/instr_bus_if.sv
verilog/fetch_resp_if.sv
verilog/prefetch_unit.sv
verilog/if_stage.sv
verilog/fetch_top.sv
bench/fetch_tb.sv

/* Makefile */
TOP := fetch_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -f fetch_top.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f fetch_top.f --top-module $(TOP)
	out="$$(./obj_dir/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -q "Test completed successfully"

clean:
	rm -rf obj_dir

/* bench/fetch_tb.sv */
// Fetch stage testbench

`timescale 1ns/1ps

module fetch_tb;

  localparam logic [31:0] BOOT_ADDR   = 32'h0000_0080;
  localparam int          DUMMY_EVERY = 3;
  localparam int          TIMEOUT     = 1000;
  // addi x0, x0, 0
  localparam logic [31:0] NOP_WORD    = 32'h0000_0013;

  logic clk, rst_n, halt_i, branch_i, id_ready_i, dummy_en_i;
  logic [31:0] branch_addr_i;
  fetch_pkg::priv_lvl_t branch_priv_i, priv_o, exp_priv;
  logic instr_req_o, instr_gnt_i, instr_rvalid_i;
  logic [31:0] instr_addr_o, instr_rdata_i;
  logic instr_valid_o, compressed_o, dummy_o;
  logic [31:0] instr_o, pc_o, exp_pc, exp_word, req_addr_q;
  logic [67:0] out_vec, hold_vec;
  logic accept, exp_dummy, dummy_mode, last_dummy, hold_q, req_wait_q;
  int real_cnt, acc_cnt, cycle_cnt, check_errs, stall_errs;
  integer seed;
  logic [31:0] pend_addr[$];
  int pend_due[$];

  fetch_top #(
    .BOOT_ADDR       (BOOT_ADDR),
    .MAX_OUTSTANDING (2),
    .FIFO_DEPTH      (4),
    .DUMMY_EVERY     (DUMMY_EVERY)
  ) dut (.*);

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // Memory contents are the word address with its halves swapped
  function automatic logic [31:0] swap_halves(input logic [31:0] a);
    return {a[15:0], a[31:16]};
  endfunction

  //////////////////////////////////////////////////
  // Memory model
  //////////////////////////////////////////////////

  // Each granted read is answered one to three cycles later, in order
  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (rst_n && instr_req_o && instr_gnt_i) begin
      pend_addr.push_back(instr_addr_o);
      pend_due.push_back(cycle_cnt + 1 + ({$random(seed)} % 3));
    end
  end

  always @(negedge clk) begin
    instr_gnt_i = ({$random(seed)} % 3) != 0;
    id_ready_i  = ({$random(seed)} % 4) != 0;
    instr_rvalid_i = 1'b0;
    instr_rdata_i  = 32'h0;
    if (pend_due.size() > 0 && pend_due[0] <= cycle_cnt) begin
      instr_rvalid_i = 1'b1;
      instr_rdata_i  = swap_halves(pend_addr.pop_front());
      void'(pend_due.pop_front());
    end
  end

  //////////////////////////////////////////////////
  // Reference state
  //////////////////////////////////////////////////

  assign accept    = instr_valid_o && id_ready_i;
  assign out_vec   = {instr_o, pc_o, priv_o, compressed_o, dummy_o};
  // A dummy is due once DUMMY_EVERY real words went to ID since the last dummy or branch
  assign exp_dummy = dummy_mode && (real_cnt == DUMMY_EVERY);
  assign exp_word  = exp_dummy ? NOP_WORD : swap_halves(exp_pc);

  always @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      exp_pc     <= BOOT_ADDR;
      exp_priv   <= fetch_pkg::PRIV_LVL_M;
      real_cnt   <= 0;
      acc_cnt    <= 0;
      dummy_mode <= 1'b0;
      last_dummy <= 1'b0;
      hold_q     <= 1'b0;
      hold_vec   <= '0;
      req_wait_q <= 1'b0;
      req_addr_q <= '0;
    end else begin
      // dummy_en_i only moves with a branch, so this tracks the mode of the loaded word
      dummy_mode <= dummy_en_i;
      hold_q     <= instr_valid_o && !id_ready_i && !branch_i;
      hold_vec   <= out_vec;
      req_wait_q <= instr_req_o && !instr_gnt_i;
      req_addr_q <= instr_addr_o;
      if (accept) begin
        acc_cnt    <= acc_cnt + 1;
        last_dummy <= dummy_o;
      end
      if (branch_i) begin
        exp_pc   <= branch_addr_i;
        exp_priv <= branch_priv_i;
        real_cnt <= 0;
      end else if (accept && exp_dummy) begin
        real_cnt <= 0;
      end else if (accept) begin
        exp_pc <= exp_pc + 32'd4;
        if (real_cnt != DUMMY_EVERY) real_cnt <= real_cnt + 1;
      end
    end
  end

  task automatic report_mismatch(input string name, input logic [67:0] exp,
                                 input logic [67:0] act);
    check_errs++;
    $display("ERR %s expected %0h actual %0h", name, exp, act);
  endtask

  //////////////////////////////////////////////////
  // Checks
  //////////////////////////////////////////////////

  a_pc : assert property (@(posedge clk) disable iff (!rst_n) accept |-> pc_o == exp_pc)
    else report_mismatch("pc", $sampled(exp_pc), $sampled(pc_o));
  a_priv : assert property (@(posedge clk) disable iff (!rst_n) accept |-> priv_o == exp_priv)
    else report_mismatch("priv", $sampled(exp_priv), $sampled(priv_o));
  a_instr : assert property (@(posedge clk) disable iff (!rst_n) accept |-> instr_o == exp_word)
    else report_mismatch("instr", $sampled(exp_word), $sampled(instr_o));
  a_compr : assert property (@(posedge clk) disable iff (!rst_n)
      accept |-> compressed_o == (exp_word[1:0] != 2'b11))
    else report_mismatch("compressed", $sampled(exp_word[1:0] != 2'b11), $sampled(compressed_o));
  a_dummy : assert property (@(posedge clk) disable iff (!rst_n) accept |-> dummy_o == exp_dummy)
    else report_mismatch("dummy", $sampled(exp_dummy), $sampled(dummy_o));
  a_dummy_pair : assert property (@(posedge clk) disable iff (!rst_n)
      (accept && dummy_o) |-> !last_dummy)
    else report_mismatch("dummy_pair", 0, 1);
  a_dummy_off : assert property (@(posedge clk) disable iff (!rst_n) !dummy_mode |-> !dummy_o)
    else report_mismatch("dummy_off", 0, 1);
  a_halt : assert property (@(posedge clk) disable iff (!rst_n) halt_i |-> !instr_valid_o)
    else report_mismatch("halt_valid", 0, 1);
  // A stalled output keeps every field, and only halt may hide it
  a_hold : assert property (@(posedge clk) disable iff (!rst_n) hold_q |-> out_vec == hold_vec)
    else report_mismatch("hold", $sampled(hold_vec), $sampled(out_vec));
  a_hold_valid : assert property (@(posedge clk) disable iff (!rst_n)
      hold_q |-> (instr_valid_o || halt_i))
    else report_mismatch("hold_valid", 1, 0);
  // A request left waiting for its grant keeps its address
  a_req_addr : assert property (@(posedge clk) disable iff (!rst_n)
      req_wait_q |-> instr_addr_o == req_addr_q)
    else report_mismatch("req_addr", $sampled(req_addr_q), $sampled(instr_addr_o));
  // The redirected read goes out one cycle after the branch at the earliest
  a_req_branch : assert property (@(posedge clk) disable iff (!rst_n)
      branch_i |-> !instr_req_o)
    else report_mismatch("req_branch", 0, 1);

  //////////////////////////////////////////////////
  // Stimulus
  //////////////////////////////////////////////////

  task automatic wait_accepts(input int n);
    int target;
    int cycles;
    target = acc_cnt + n;
    cycles = 0;
    while (acc_cnt < target && cycles < TIMEOUT) begin
      @(negedge clk);
      cycles++;
    end
    if (acc_cnt < target) begin
      stall_errs++;
      $display("Stall: fewer than %0d instructions reached ID in %0d cycles", n, TIMEOUT);
    end
  endtask

  // One-cycle branch pulse to a random word address and level
  task automatic do_branch(input logic dummy_en);
    int sel;
    sel = {$random(seed)} % 3;
    branch_i      = 1'b1;
    branch_addr_i = {$random(seed)} & 32'h000f_fffc;
    dummy_en_i    = dummy_en;
    case (sel)
      0:       branch_priv_i = fetch_pkg::PRIV_LVL_U;
      1:       branch_priv_i = fetch_pkg::PRIV_LVL_S;
      default: branch_priv_i = fetch_pkg::PRIV_LVL_M;
    endcase
    @(negedge clk);
    branch_i = 1'b0;
  endtask

  initial begin
    seed = 32'hdf9b5841;
    check_errs = 0;
    stall_errs = 0;
    cycle_cnt = 0;
    rst_n = 1'b0;
    halt_i = 1'b0;
    branch_i = 1'b0;
    branch_addr_i = 32'h0;
    branch_priv_i = fetch_pkg::PRIV_LVL_M;
    id_ready_i = 1'b0;
    dummy_en_i = 1'b0;
    instr_gnt_i = 1'b0;
    instr_rvalid_i = 1'b0;
    instr_rdata_i = 32'h0;
    repeat (8) @(negedge clk);
    rst_n = 1'b1;
    wait_accepts(20);
    // First halt window with the FIFO filling behind it
    halt_i = 1'b1;
    repeat (12) @(negedge clk);
    halt_i = 1'b0;
    wait_accepts(15);
    do_branch(1'b0);
    wait_accepts(12);
    // Dummy phase
    do_branch(1'b1);
    wait_accepts(30);
    // Second halt window, killed by a branch in its middle
    halt_i = 1'b1;
    repeat (5) @(negedge clk);
    do_branch(1'b1);
    repeat (5) @(negedge clk);
    halt_i = 1'b0;
    wait_accepts(20);
    do_branch(1'b0);
    wait_accepts(20);
    repeat (4) @(negedge clk);
    $display("Check errors: %0d, stalls: %0d", check_errs, stall_errs);
    if (check_errs == 0 && stall_errs == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

/* verilog/fetch_top.sv */
// Instruction fetch top level

`timescale 1ns/1ps

module fetch_top #(
  parameter logic [31:0] BOOT_ADDR       = 32'h0000_0080,
  parameter int          MAX_OUTSTANDING = 2,
  parameter int          FIFO_DEPTH      = 4,
  parameter int          DUMMY_EVERY     = 3
) (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 halt_i,
  input  logic                 branch_i,
  input  logic [31:0]          branch_addr_i,
  input  fetch_pkg::priv_lvl_t branch_priv_i,
  input  logic                 id_ready_i,
  input  logic                 dummy_en_i,
  output logic                 instr_req_o,
  output logic [31:0]          instr_addr_o,
  input  logic                 instr_gnt_i,
  input  logic                 instr_rvalid_i,
  input  logic [31:0]          instr_rdata_i,
  output logic                 instr_valid_o,
  output logic [31:0]          instr_o,
  output logic [31:0]          pc_o,
  output fetch_pkg::priv_lvl_t priv_o,
  output logic                 compressed_o,
  output logic                 dummy_o
);

  instr_bus_if  bus ();
  fetch_resp_if resp ();

  // Memory side of the bus maps straight onto the pins
  assign instr_req_o  = bus.req;
  assign instr_addr_o = bus.addr;
  assign bus.gnt      = instr_gnt_i;
  assign bus.rvalid   = instr_rvalid_i;
  assign bus.rdata    = instr_rdata_i;

  prefetch_unit #(
    .BOOT_ADDR       (BOOT_ADDR),
    .MAX_OUTSTANDING (MAX_OUTSTANDING),
    .FIFO_DEPTH      (FIFO_DEPTH)
  ) u_prefetch (
    .clk           (clk),
    .rst_n         (rst_n),
    .branch_i      (branch_i),
    .branch_addr_i (branch_addr_i),
    .branch_priv_i (branch_priv_i),
    .bus           (bus.master),
    .resp          (resp.source)
  );

  if_stage #(
    .DUMMY_EVERY (DUMMY_EVERY)
  ) u_if_stage (
    .clk           (clk),
    .rst_n         (rst_n),
    .halt_i        (halt_i),
    .branch_i      (branch_i),
    .id_ready_i    (id_ready_i),
    .dummy_en_i    (dummy_en_i),
    .resp          (resp.sink),
    .instr_valid_o (instr_valid_o),
    .instr_o       (instr_o),
    .pc_o          (pc_o),
    .priv_o        (priv_o),
    .compressed_o  (compressed_o),
    .dummy_o       (dummy_o)
  );

endmodule

/* verilog/if_stage.sv */
// Instruction fetch stage

`timescale 1ns/1ps

module if_stage #(
  parameter int DUMMY_EVERY = 3
) (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 halt_i,
  input  logic                 branch_i,
  input  logic                 id_ready_i,
  input  logic                 dummy_en_i,
  fetch_resp_if.sink           resp,
  output logic                 instr_valid_o,
  output logic [31:0]          instr_o,
  output logic [31:0]          pc_o,
  output fetch_pkg::priv_lvl_t priv_o,
  output logic                 compressed_o,
  output logic                 dummy_o
);

  localparam int CNT_W = (DUMMY_EVERY > 0) ? $clog2(DUMMY_EVERY + 1) : 1;

  logic                 valid_q;
  logic                 dummy_q;
  logic [31:0]          instr_q;
  logic [31:0]          pc_q;
  logic                 compressed_q;
  fetch_pkg::priv_lvl_t priv_q;
  logic [CNT_W-1:0]     real_cnt_q;
  logic                 load_slot;
  logic                 dummy_insert;
  logic                 load;
  logic                 pop;
  logic [31:0]          load_word;
  logic                 acc_dummy_q;
  logic                 epoch_set_q;
  fetch_pkg::priv_lvl_t epoch_priv_q;

  //////////////////////////////////////////////////
  // Load control
  //////////////////////////////////////////////////

  // The register takes a new entry when empty or consumed, never under halt
  assign load_slot = (!valid_q || id_ready_i) && !halt_i;

  // A dummy borrows the FIFO head's PC and level but leaves the word in place
  assign dummy_insert = dummy_en_i && (real_cnt_q == CNT_W'(DUMMY_EVERY)) && resp.valid;

  // Kill drains the head whatever state the stage is in
  assign resp.ready = branch_i || (load_slot && !dummy_insert);
  assign pop        = resp.valid && resp.ready;
  assign load       = load_slot && resp.valid && !branch_i;
  assign load_word  = dummy_insert ? fetch_pkg::NOP_INSTR : resp.rdata;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      valid_q    <= 1'b0;
      dummy_q    <= 1'b0;
      priv_q     <= fetch_pkg::PRIV_LVL_M;
      real_cnt_q <= '0;
    end else if (branch_i) begin
      valid_q    <= 1'b0;
      dummy_q    <= 1'b0;
      real_cnt_q <= '0;
    end else if (load_slot) begin
      valid_q <= resp.valid;
      dummy_q <= dummy_insert;
      if (load) begin
        priv_q <= resp.priv;
        // Count real words up to the dummy threshold
        if (dummy_insert) begin
          real_cnt_q <= '0;
        end else if (real_cnt_q != CNT_W'(DUMMY_EVERY)) begin
          real_cnt_q <= real_cnt_q + 1'b1;
        end
      end
    end
  end

  // IF/ID payload
  always_ff @(posedge clk) begin
    if (load) begin
      instr_q      <= load_word;
      pc_q         <= resp.addr;
      compressed_q <= fetch_pkg::is_compressed(load_word);
    end
  end

  // Halt hides the entry but the register keeps it
  assign instr_valid_o = valid_q && !halt_i;
  assign instr_o       = instr_q;
  assign pc_o          = pc_q;
  assign priv_o        = priv_q;
  assign compressed_o  = compressed_q;
  assign dummy_o       = dummy_q;

  //////////////////////////////////////////////////
  // Assertions
  //////////////////////////////////////////////////

  // Reference state: last accepted kind and the level seen since the last branch
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      acc_dummy_q  <= 1'b0;
      epoch_set_q  <= 1'b0;
      epoch_priv_q <= fetch_pkg::PRIV_LVL_M;
    end else begin
      if (instr_valid_o && id_ready_i) begin
        acc_dummy_q <= dummy_o;
      end
      if (branch_i) begin
        epoch_set_q <= 1'b0;
      end else if (instr_valid_o && !epoch_set_q) begin
        epoch_set_q  <= 1'b1;
        epoch_priv_q <= priv_o;
      end
    end
  end

  a_halt : assert property (@(posedge clk) disable iff (!rst_n)
      (halt_i && !branch_i) |-> (!pop && !instr_valid_o))
    else $error("if_stage: halt did not stop the stage");

  a_kill : assert property (@(posedge clk) disable iff (!rst_n)
      branch_i |-> resp.ready ##1 !instr_valid_o)
    else $error("if_stage: kill left the stage busy");

  // The FIFO head stays put under a dummy, so the next real word shares its PC
  a_dummy_no_pop : assert property (@(posedge clk) disable iff (!rst_n)
      (load && dummy_insert) |=> (resp.valid && (resp.addr == $past(resp.addr))))
    else $error("if_stage: FIFO popped for a dummy");

  a_no_dummy_pair : assert property (@(posedge clk) disable iff (!rst_n)
      (instr_valid_o && id_ready_i && dummy_o) |-> !acc_dummy_q)
    else $error("if_stage: two dummies in a row");

  // Every instruction on one path carries the level that its branch set
  a_priv_after_branch : assert property (@(posedge clk) disable iff (!rst_n)
      (instr_valid_o && epoch_set_q) |-> (priv_o == epoch_priv_q))
    else $error("if_stage: privilege level changed without a branch");

endmodule

/* verilog/prefetch_unit.sv */
// Instruction prefetch unit

`timescale 1ns/1ps

module prefetch_unit #(
  parameter logic [31:0] BOOT_ADDR       = 32'h0000_0080,
  parameter int          MAX_OUTSTANDING = 2,
  parameter int          FIFO_DEPTH      = 4
) (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 branch_i,
  input  logic [31:0]          branch_addr_i,
  input  fetch_pkg::priv_lvl_t branch_priv_i,
  instr_bus_if.master          bus,
  fetch_resp_if.source         resp
);

  // FIFO_DEPTH is never below MAX_OUTSTANDING, so one width fits all counters
  localparam int CNT_W = $clog2(FIFO_DEPTH + 1);
  localparam int SUM_W = CNT_W + 1;
  localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;

  typedef struct packed {
    logic [31:0]          addr;
    logic [31:0]          data;
    fetch_pkg::priv_lvl_t priv;
  } entry_t;

  entry_t               fifo_mem [FIFO_DEPTH];
  logic [PTR_W-1:0]     wr_ptr_q;
  logic [PTR_W-1:0]     rd_ptr_q;
  logic [CNT_W-1:0]     fifo_cnt_q;
  logic [CNT_W-1:0]     out_cnt_q;
  logic [CNT_W-1:0]     drop_cnt_q;
  logic [SUM_W-1:0]     in_use;
  logic [31:0]          fetch_addr_q;
  logic [31:0]          resp_addr_q;
  logic [31:0]          branch_target;
  fetch_pkg::priv_lvl_t priv_q;
  logic                 req_en_q;
  logic                 room;
  logic                 issue;
  logic                 push;
  logic                 pop;

  //////////////////////////////////////////////////
  // Request side
  //////////////////////////////////////////////////

  assign branch_target = {branch_addr_i[31:2], 2'b00};

  // Buffered words plus reads in flight must never exceed the FIFO size
  assign in_use = fifo_cnt_q + out_cnt_q;
  assign room   = (in_use < SUM_W'(FIFO_DEPTH)) && (out_cnt_q < CNT_W'(MAX_OUTSTANDING));

  // No read goes out in the branch cycle, the new target follows one cycle later
  assign bus.req  = req_en_q && room && !branch_i;
  assign bus.addr = fetch_addr_q;
  assign issue    = bus.req && bus.gnt;

  //////////////////////////////////////////////////
  // Response side
  //////////////////////////////////////////////////

  // Responses still owed to reads from before a branch are thrown away
  assign push = bus.rvalid && (drop_cnt_q == '0) && !branch_i;
  assign pop  = resp.valid && resp.ready;

  assign resp.valid = (fifo_cnt_q != '0);
  assign resp.addr  = fifo_mem[rd_ptr_q].addr;
  assign resp.rdata = fifo_mem[rd_ptr_q].data;
  assign resp.priv  = fifo_mem[rd_ptr_q].priv;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      req_en_q     <= 1'b0;
      fetch_addr_q <= BOOT_ADDR;
      resp_addr_q  <= BOOT_ADDR;
      priv_q       <= fetch_pkg::PRIV_LVL_M;
      out_cnt_q    <= '0;
      drop_cnt_q   <= '0;
      fifo_cnt_q   <= '0;
      wr_ptr_q     <= '0;
      rd_ptr_q     <= '0;
    end else begin
      // Requests start one cycle out of reset
      req_en_q  <= 1'b1;
      out_cnt_q <= out_cnt_q + CNT_W'(issue) - CNT_W'(bus.rvalid);
      if (branch_i) begin
        fetch_addr_q <= branch_target;
        resp_addr_q  <= branch_target;
        priv_q       <= branch_priv_i;
        // Every read still pending after this cycle belongs to the old path
        drop_cnt_q   <= out_cnt_q - CNT_W'(bus.rvalid);
        fifo_cnt_q   <= '0;
        wr_ptr_q     <= '0;
        rd_ptr_q     <= '0;
      end else begin
        if (issue) begin
          fetch_addr_q <= fetch_addr_q + 32'd4;
        end
        if (bus.rvalid && (drop_cnt_q != '0)) begin
          drop_cnt_q <= drop_cnt_q - 1'b1;
        end
        // Reads are sequential, so the response address is a second counter
        if (push) begin
          resp_addr_q <= resp_addr_q + 32'd4;
          wr_ptr_q    <= (wr_ptr_q == PTR_W'(FIFO_DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
        end
        if (pop) begin
          rd_ptr_q <= (rd_ptr_q == PTR_W'(FIFO_DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
        end
        fifo_cnt_q <= fifo_cnt_q + CNT_W'(push) - CNT_W'(pop);
      end
    end
  end

  // Entry storage
  always_ff @(posedge clk) begin
    if (push) begin
      fifo_mem[wr_ptr_q] <= '{addr: resp_addr_q, data: bus.rdata, priv: priv_q};
    end
  end

  //////////////////////////////////////////////////
  // Assertions
  //////////////////////////////////////////////////

  a_req_aligned : assert property (@(posedge clk) disable iff (!rst_n)
      bus.req |-> (bus.addr[1:0] == 2'b00))
    else $error("prefetch_unit: unaligned fetch address");

  a_outstanding_max : assert property (@(posedge clk) disable iff (!rst_n)
      out_cnt_q <= CNT_W'(MAX_OUTSTANDING))
    else $error("prefetch_unit: too many reads in flight");

  // The memory side must never answer a read that was not granted
  a_no_stray_rvalid : assert property (@(posedge clk) disable iff (!rst_n)
      bus.rvalid |-> (out_cnt_q != '0))
    else $error("prefetch_unit: rvalid with no read outstanding");

endmodule

/* verilog/fetch_resp_if.sv */
// Fetched word interface

`timescale 1ns/1ps

interface fetch_resp_if;

  // valid shows the FIFO head and a pop needs valid and ready together
  logic                 valid;
  logic                 ready;
  logic [31:0]          addr;
  logic [31:0]          rdata;
  // Privilege level in force when the read went out
  fetch_pkg::priv_lvl_t priv;

  modport source (
    output valid, addr, rdata, priv,
    input  ready
  );

  modport sink (
    input  valid, addr, rdata, priv,
    output ready
  );

endinterface

/* verilog/instr_bus_if.sv */
// Instruction bus interface

`timescale 1ns/1ps

interface instr_bus_if;

  // Request phase, a read is taken when req and gnt meet
  logic        req;
  logic        gnt;
  logic [31:0] addr;

  // Response phase, one rvalid pulse per granted read, in order
  logic        rvalid;
  logic [31:0] rdata;

  // The prefetch unit issues the reads
  modport master (
    output req, addr,
    input  gnt, rvalid, rdata
  );

  // Memory side, seen through the top level ports
  modport slave (
    input  req, addr,
    output gnt, rvalid, rdata
  );

endinterface

/* verilog/fetch_pkg.sv */
// Fetch stage definitions

package fetch_pkg;

  //////////////////////////////////////////////////
  // Privilege levels
  //////////////////////////////////////////////////

  // Encoding follows the RISC-V privileged spec, level 2 is reserved
  typedef enum logic [1:0] {
    PRIV_LVL_U = 2'b00,
    PRIV_LVL_S = 2'b01,
    PRIV_LVL_M = 2'b11
  } priv_lvl_t;

  //////////////////////////////////////////////////
  // Instruction encodings
  //////////////////////////////////////////////////

  // addi x0, x0, 0 is the canonical NOP and goes out as the dummy
  localparam logic [31:0] NOP_INSTR = 32'h0000_0013;

  // A 32-bit instruction always has both low opcode bits set
  // Anything else belongs to the compressed 16-bit space
  function automatic logic is_compressed(input logic [31:0] word);
    logic low_ones;
    low_ones = (word[1:0] == 2'b11);
    return !low_ones;
  endfunction

endpackage
